// File: verilog/accel_dma_pkg.sv
package accel_dma_pkg;

  // Memory geometry
  localparam int LINE_BYTES      = 16;
  localparam int MASK_BITS       = 4;
  localparam int ADDR_WIDTH      = 12;
  localparam int LEN_WIDTH       = 10;
  localparam int LINE_ADDR_WIDTH = 8;
  localparam int BANK_ADDR_WIDTH = 7;
  localparam int LINE_CNT_WIDTH  = 7;

  // Buffering and output stream
  localparam int FIFO_LINES      = 4;
  localparam int OUT_BYTES       = 4;

  typedef struct packed {
    logic [ADDR_WIDTH-1:0] addr;
    logic [LEN_WIDTH-1:0]  len;
  } desc_t;

  // ptr is all ones except on the last line of a transfer
  typedef struct packed {
    logic [LINE_ADDR_WIDTH-1:0] line_addr;
    logic [MASK_BITS-1:0]       offset;
    logic [MASK_BITS-1:0]       ptr;
    logic                       last;
  } line_req_t;

  typedef struct packed {
    logic                       even_en;
    logic [BANK_ADDR_WIDTH-1:0] even_addr;
    logic                       odd_en;
    logic [BANK_ADDR_WIDTH-1:0] odd_addr;
  } bank_rd_t;

  typedef struct packed {
    logic [8*LINE_BYTES-1:0] data;
    logic [MASK_BITS-1:0]    ptr;
    logic                    last;
  } line_beat_t;

  typedef struct packed {
    logic [8*OUT_BYTES-1:0] data;
    logic [OUT_BYTES-1:0]   keep;
    logic                   last;
  } out_beat_t;

  typedef enum logic {
    ST_IDLE,
    ST_ACTIVE
  } dma_state_e;

endpackage

// File: verilog/dual_bank_mem.sv
`timescale 1ns/10ps

module dual_bank_mem
  import accel_dma_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst,

  // Host write port, one full line per write
  input  logic                       wr_en,
  input  logic [LINE_ADDR_WIDTH-1:0] wr_line,
  input  logic [8*LINE_BYTES-1:0]    wr_data,

  // Read port for both banks
  input  bank_rd_t                   rd,
  output logic [8*LINE_BYTES-1:0]    even_data,
  output logic [8*LINE_BYTES-1:0]    odd_data
);

  logic [8*LINE_BYTES-1:0] even_bank [0:2**BANK_ADDR_WIDTH-1];
  logic [8*LINE_BYTES-1:0] odd_bank  [0:2**BANK_ADDR_WIDTH-1];

  logic [BANK_ADDR_WIDTH-1:0] wr_bank_addr;

  // Low line bit picks the bank, the rest is the row
  assign wr_bank_addr = wr_line[LINE_ADDR_WIDTH-1:1];

  always_ff @(posedge clk) begin
    if (wr_en && !wr_line[0]) begin
      even_bank[wr_bank_addr] <= wr_data;
    end
    if (wr_en && wr_line[0]) begin
      odd_bank[wr_bank_addr] <= wr_data;
    end
  end

  // Registered reads, one cycle after the enable
  always_ff @(posedge clk) begin
    if (rst) begin
      even_data <= '0;
      odd_data  <= '0;
    end else begin
      if (rd.even_en) begin
        even_data <= even_bank[rd.even_addr];
      end
      if (rd.odd_en) begin
        odd_data <= odd_bank[rd.odd_addr];
      end
    end
  end

endmodule

// File: verilog/rd_desc_ctrl.sv
`timescale 1ns/10ps

module rd_desc_ctrl
  import accel_dma_pkg::*;
(
  input  logic      clk,
  input  logic      rst,

  // Descriptor port
  input  desc_t     desc,
  input  logic      desc_valid,
  output logic      desc_ready,
  input  logic      stop,

  // Issue control
  input  logic      credit_ok,
  output line_req_t req,
  output logic      req_valid,
  output bank_rd_t  bank_rd,
  output logic      flush
);

  dma_state_e state;
  logic       stop_r;

  // Working copy of the parsed descriptor
  logic [LINE_ADDR_WIDTH-1:0] cur_addr;
  logic [LINE_CNT_WIDTH-1:0]  cur_cnt;
  logic [MASK_BITS-1:0]       cur_offset;
  logic [MASK_BITS-1:0]       final_ptr;

  logic [LINE_ADDR_WIDTH-1:0] next_addr;
  logic [MASK_BITS-1:0]       len_rem;
  logic                       desc_take;
  logic                       last_line;

  assign desc_ready = (state == ST_IDLE);
  assign desc_take  = desc_valid && desc_ready;
  assign len_rem    = desc.len[MASK_BITS-1:0];
  assign flush      = stop_r;

  // Stop stays set until a new descriptor shows up
  always_ff @(posedge clk) begin
    if (rst) begin
      stop_r <= 1'b0;
    end else if (desc_valid) begin
      stop_r <= 1'b0;
    end else begin
      stop_r <= stop_r | stop;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: begin
          if (desc_take) begin
            state <= ST_ACTIVE;
          end
        end
        ST_ACTIVE: begin
          if (stop_r || (req_valid && last_line)) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Parse on acceptance, then walk one line per issued request
  always_ff @(posedge clk) begin
    if (desc_take) begin
      cur_addr   <= desc.addr[ADDR_WIDTH-1:MASK_BITS];
      cur_offset <= desc.addr[MASK_BITS-1:0];
      // Partial tail line counts as a whole line
      cur_cnt    <= LINE_CNT_WIDTH'(desc.len[LEN_WIDTH-1:MASK_BITS]) +
                    LINE_CNT_WIDTH'(len_rem != '0);
      // Remainder of zero wraps to all ones, a full last line
      final_ptr  <= len_rem - 1'b1;
    end else if (req_valid) begin
      cur_addr <= next_addr;
      cur_cnt  <= cur_cnt - 1'b1;
    end
  end

  always_comb begin
    next_addr = cur_addr + 1'b1;
    last_line = (cur_cnt == LINE_CNT_WIDTH'(1));
    req_valid = (state == ST_ACTIVE) && credit_ok && !stop_r;

    req.line_addr = cur_addr;
    req.offset    = cur_offset;
    req.last      = last_line;
    req.ptr       = last_line ? final_ptr : '1;

    // Line A and A+1 always land in opposite banks
    bank_rd.even_en   = req_valid;
    bank_rd.odd_en    = req_valid;
    bank_rd.odd_addr  = cur_addr[LINE_ADDR_WIDTH-1:1];
    bank_rd.even_addr = cur_addr[0] ? next_addr[LINE_ADDR_WIDTH-1:1] :
                                      cur_addr[LINE_ADDR_WIDTH-1:1];
  end

endmodule

// File: verilog/line_credit_cnt.sv
`timescale 1ns/10ps

module line_credit_cnt
  import accel_dma_pkg::*;
(
  input  logic clk,
  input  logic rst,
  input  logic issue,
  input  logic consume,
  input  logic flush,
  output logic credit_ok
);

  // Lines requested from memory and not yet popped from the FIFO
  logic [$clog2(FIFO_LINES):0] count;

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      count <= '0;
    end else if (issue && !consume) begin
      count <= count + 1'b1;
    end else if (consume && !issue) begin
      count <= count - 1'b1;
    end
  end

  // Room for every line in flight, so the FIFO never overflows
  assign credit_ok = (count < FIFO_LINES);

endmodule

// File: verilog/line_aligner.sv
`timescale 1ns/10ps

module line_aligner
  import accel_dma_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst,

  // Request metadata, same cycle as the bank read enables
  input  line_req_t               req,
  input  logic                    req_valid,

  // Bank words, one cycle after the request
  input  logic [8*LINE_BYTES-1:0] even_data,
  input  logic [8*LINE_BYTES-1:0] odd_data,

  // Aligned line towards the FIFO
  output line_beat_t              beat,
  output logic                    beat_valid
);

  line_req_t req_d;
  logic      req_valid_d;

  logic [2*8*LINE_BYTES-1:0] joined;
  logic [2*8*LINE_BYTES-1:0] shifted;

  always_ff @(posedge clk) begin
    if (rst) begin
      req_valid_d <= 1'b0;
      beat_valid  <= 1'b0;
    end else begin
      req_valid_d <= req_valid;
      beat_valid  <= req_valid_d;
    end
  end

  // Metadata follows the memory read register
  always_ff @(posedge clk) begin
    req_d <= req;
  end

  always_comb begin
    // Line A goes in the low half, line A+1 above it
    if (req_d.line_addr[0]) begin
      joined = {even_data, odd_data};
    end else begin
      joined = {odd_data, even_data};
    end
    shifted = joined >> {req_d.offset, 3'b000};
  end

  always_ff @(posedge clk) begin
    beat.data <= shifted[8*LINE_BYTES-1:0];
    beat.ptr  <= req_d.ptr;
    beat.last <= req_d.last;
  end

endmodule

// File: verilog/line_fifo.sv
`timescale 1ns/10ps

module line_fifo
  import accel_dma_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       clear,

  // Write side, no ready since credit keeps room
  input  line_beat_t in_beat,
  input  logic       in_valid,

  // Read side
  output line_beat_t out_beat,
  output logic       out_valid,
  input  logic       out_ready
);

  line_beat_t slots [0:FIFO_LINES-1];

  // One extra bit tells full from empty
  logic [$clog2(FIFO_LINES):0] wr_ptr;
  logic [$clog2(FIFO_LINES):0] rd_ptr;
  logic                        pop;

  assign out_valid = (wr_ptr != rd_ptr);
  assign out_beat  = slots[rd_ptr[$clog2(FIFO_LINES)-1:0]];
  assign pop       = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (in_valid) begin
      slots[wr_ptr[$clog2(FIFO_LINES)-1:0]] <= in_beat;
    end
  end

  always_ff @(posedge clk) begin
    if (rst || clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (in_valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

endmodule

// File: verilog/accel_width_conv.sv
`timescale 1ns/10ps

module accel_width_conv
  import accel_dma_pkg::*;
(
  input  logic       clk,
  input  logic       rst,

  // Whole lines from the FIFO
  input  line_beat_t in_beat,
  input  logic       in_valid,
  output logic       in_ready,

  // Narrow stream to the accelerator
  output out_beat_t  out,
  output logic       out_valid,
  input  logic       out_ready
);

  logic [MASK_BITS-$clog2(OUT_BYTES)-1:0] chunk;
  logic                                   last_chunk;
  logic                                   adv;
  logic [OUT_BYTES-1:0]                   tail_keep;

  // Final chunk is the one holding the last valid byte
  assign last_chunk = (chunk == in_beat.ptr[MASK_BITS-1:$clog2(OUT_BYTES)]);
  assign adv        = !out_valid || out_ready;
  assign in_ready   = in_valid && adv && last_chunk;

  // Keep bytes 0 up to the low bits of ptr
  assign tail_keep = {OUT_BYTES{1'b1}} >>
                     (OUT_BYTES - 1 - in_beat.ptr[$clog2(OUT_BYTES)-1:0]);

  // A drop in valid means the FIFO was flushed, start over at chunk 0
  always_ff @(posedge clk) begin
    if (rst || !in_valid) begin
      chunk <= '0;
    end else if (adv) begin
      chunk <= last_chunk ? '0 : chunk + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else if (adv) begin
      out_valid <= in_valid;
    end
  end

  // Payload only moves when the sink can take it
  always_ff @(posedge clk) begin
    if (adv) begin
      out.data <= in_beat.data[chunk*8*OUT_BYTES +: 8*OUT_BYTES];
      out.keep <= (in_beat.last && last_chunk) ? tail_keep : '1;
      out.last <= in_beat.last && last_chunk;
    end
  end

endmodule

// File: verilog/accel_rd_dma_top.sv
`timescale 1ns/10ps

module accel_rd_dma_top
  import accel_dma_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst,

  // Descriptor and abort
  input  desc_t                      desc,
  input  logic                       desc_valid,
  output logic                       desc_ready,
  input  logic                       stop,

  // Host load port
  input  logic                       wr_en,
  input  logic [LINE_ADDR_WIDTH-1:0] wr_line,
  input  logic [8*LINE_BYTES-1:0]    wr_data,

  // Output stream
  output out_beat_t                  out,
  output logic                       out_valid,
  input  logic                       out_ready
);

  line_req_t               req;
  logic                    req_valid;
  bank_rd_t                bank_rd;
  logic                    flush;
  logic                    credit_ok;
  logic [8*LINE_BYTES-1:0] even_data;
  logic [8*LINE_BYTES-1:0] odd_data;
  line_beat_t              beat;
  logic                    beat_valid;
  line_beat_t              fifo_beat;
  logic                    fifo_valid;
  logic                    fifo_ready;

  rd_desc_ctrl u_ctrl (
    .clk(clk), .rst(rst), .desc(desc), .desc_valid(desc_valid),
    .desc_ready(desc_ready), .stop(stop), .credit_ok(credit_ok),
    .req(req), .req_valid(req_valid), .bank_rd(bank_rd), .flush(flush)
  );

  line_credit_cnt u_credit (
    .clk(clk), .rst(rst), .issue(req_valid), .consume(fifo_ready),
    .flush(flush), .credit_ok(credit_ok)
  );

  dual_bank_mem u_mem (
    .clk(clk), .rst(rst), .wr_en(wr_en), .wr_line(wr_line), .wr_data(wr_data),
    .rd(bank_rd), .even_data(even_data), .odd_data(odd_data)
  );

  line_aligner u_align (
    .clk(clk), .rst(rst), .req(req), .req_valid(req_valid),
    .even_data(even_data), .odd_data(odd_data), .beat(beat), .beat_valid(beat_valid)
  );

  line_fifo u_fifo (
    .clk(clk), .rst(rst), .clear(flush), .in_beat(beat), .in_valid(beat_valid),
    .out_beat(fifo_beat), .out_valid(fifo_valid), .out_ready(fifo_ready)
  );

  accel_width_conv u_conv (
    .clk(clk), .rst(rst), .in_beat(fifo_beat), .in_valid(fifo_valid),
    .in_ready(fifo_ready), .out(out), .out_valid(out_valid), .out_ready(out_ready)
  );

endmodule

// File: dv/tb_clk_gen.sv
`timescale 1ns/10ps

module tb_clk_gen (
  output logic clk,
  output logic rst
);

  // 20 ns period
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Reset held over the first three rising edges
  initial begin
    rst = 1'b1;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

// File: dv/accel_rd_dma_tb.sv
`timescale 1ns/10ps

module accel_rd_dma_tb
  import accel_dma_pkg::*;
();

  localparam int TIMEOUT  = 2000;
  localparam int N_ROWS   = 26;
  // At most one line of beats may still drain after a stop
  localparam int MAX_LEAK = OUT_BYTES;

  // stop_at of zero lets the transfer run to its last beat
  typedef struct packed {
    desc_t      d;
    logic       bp;
    logic [7:0] stop_at;
  } row_t;

  logic                       clk;
  logic                       rst;
  desc_t                      desc;
  logic                       desc_valid;
  logic                       desc_ready;
  logic                       stop;
  logic                       wr_en;
  logic [LINE_ADDR_WIDTH-1:0] wr_line;
  logic [8*LINE_BYTES-1:0]    wr_data;
  out_beat_t                  out;
  logic                       out_valid;
  logic                       out_ready;

  logic [7:0] mem_model [0:2**ADDR_WIDTH-1];
  row_t       rows [0:N_ROWS-1];
  out_beat_t  exp_q [$];
  integer     seed;

  tb_clk_gen clk_gen (.*);

  accel_rd_dma_top uut (.*);

  task automatic fail_and_stop();
    $display("Simulation FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic count_wait(inout int timer, input string what);
    timer++;
    if (timer > TIMEOUT) begin
      $display("Timed out after %0d cycles waiting for %s", TIMEOUT, what);
      fail_and_stop();
    end
  endtask

  task automatic check_ready(input string name, input logic got, input logic want);
    if (got !== want) begin
      $display("Fail at %0t: %s got %b, expected %b", $time, name, got, want);
      fail_and_stop();
    end
  endtask

  // Data bytes outside keep are don't care
  task automatic check_beat(input out_beat_t got, input out_beat_t want);
    logic [8*OUT_BYTES-1:0] mask;
    for (int i = 0; i < OUT_BYTES; i++) begin
      mask[8*i +: 8] = {8{want.keep[i]}};
    end
    if ((got.data & mask) !== (want.data & mask) || got.keep !== want.keep ||
        got.last !== want.last) begin
      $display("Fail at %0t: out data/keep/last got %h/%b/%b, expected %h/%b/%b", $time,
               got.data, got.keep, got.last, want.data, want.keep, want.last);
      fail_and_stop();
    end
  endtask

  // Bytes addr to addr+len-1 in groups of four, short group at the end
  task automatic build_expected(input desc_t d);
    out_beat_t b;
    int        n;
    exp_q.delete();
    b = '0;
    for (int i = 0; i < int'(d.len); i++) begin
      n = i % OUT_BYTES;
      b.data[8*n +: 8] = mem_model[int'(d.addr) + i];
      b.keep[n]        = 1'b1;
      if (n == OUT_BYTES - 1 || i == int'(d.len) - 1) begin
        b.last = (i == int'(d.len) - 1);
        exp_q.push_back(b);
        b = '0;
      end
    end
  endtask

  task automatic run_row(input row_t r);
    int     timer;
    int     beats;
    int     quiet;
    int     leaked;
    integer rnd;
    logic   seen;
    build_expected(r.d);
    @(posedge clk);
    desc       <= r.d;
    desc_valid <= 1'b1;
    timer = 0;
    seen  = 1'b0;
    while (!seen) begin
      @(negedge clk);
      count_wait(timer, "desc_ready");
      seen = desc_ready;
      @(posedge clk);
    end
    desc_valid <= 1'b0;
    timer = 0;
    beats = 0;
    while (beats < exp_q.size() && (r.stop_at == 0 || beats < int'(r.stop_at))) begin
      rnd = $random(seed);
      // About one cycle in four stalls the sink
      out_ready <= !r.bp || (rnd[1:0] != 2'b00);
      @(negedge clk);
      count_wait(timer, "an output beat");
      if (out_valid && out_ready) begin
        check_beat(out, exp_q[beats]);
        beats++;
        timer = 0;
      end
      @(posedge clk);
    end
    if (beats < exp_q.size()) begin
      // Abort mid-transfer, then drop whatever still comes out
      stop      <= 1'b1;
      out_ready <= 1'b1;
      @(posedge clk);
      stop  <= 1'b0;
      timer  = 0;
      quiet  = 0;
      leaked = 0;
      while (quiet < 8) begin
        @(negedge clk);
        count_wait(timer, "desc_ready and an idle output after stop");
        if (out_valid && out_ready) begin
          leaked++;
        end
        if (leaked > MAX_LEAK) begin
          $display("Stream kept running after stop, %0d beats came out", leaked);
          fail_and_stop();
        end
        quiet = (desc_ready && !out_valid) ? quiet + 1 : 0;
      end
    end else begin
      // Nothing may follow the last beat
      for (int c = 0; c < 8; c++) begin
        @(negedge clk);
        check_ready("out_valid", out_valid, 1'b0);
        check_ready("desc_ready", desc_ready, 1'b1);
      end
    end
  endtask

  initial begin
    int     timer;
    integer rnd;
    logic   in_reset;
    seed       = 52;
    desc       = '0;
    desc_valid = 1'b0;
    stop       = 1'b0;
    wr_en      = 1'b0;
    wr_line    = '0;
    wr_data    = '0;
    out_ready  = 1'b0;

    // addr, len, back-pressure, stop after this many beats
    rows[0] = {12'h000, 10'd64,  1'b0, 8'd0};
    rows[1] = {12'h0f0, 10'd48,  1'b1, 8'd0};
    rows[2] = {12'h013, 10'd50,  1'b0, 8'd0};
    rows[3] = {12'h013, 10'd50,  1'b1, 8'd0};
    rows[4] = {12'h3a7, 10'd301, 1'b1, 8'd0};
    rows[5] = {12'h400, 10'd256, 1'b0, 8'd10};
    rows[6] = {12'h00d, 10'd3,   1'b0, 8'd0};
    rows[7] = {12'h555, 10'd200, 1'b1, 8'd7};
    rows[8] = {12'h0e1, 10'd33,  1'b1, 8'd0};
    rows[9] = {12'h7f9, 10'd130, 1'b0, 8'd0};
    // Every byte offset, lengths cycling through the tail keeps
    for (int k = 0; k < LINE_BYTES; k++) begin
      rows[10+k] = {ADDR_WIDTH'(12'h800 + 17*k), LEN_WIDTH'(1 + 5*k), k[0], 8'd0};
    end

    timer    = 0;
    in_reset = 1'b1;
    while (in_reset) begin
      @(negedge clk);
      count_wait(timer, "reset release");
      in_reset = rst;
    end
    check_ready("desc_ready", desc_ready, 1'b1);
    check_ready("out_valid", out_valid, 1'b0);

    // Same random bytes go to the model and to the DUT memory
    for (int l = 0; l < 2**LINE_ADDR_WIDTH; l++) begin
      @(posedge clk);
      wr_en   <= 1'b1;
      wr_line <= LINE_ADDR_WIDTH'(l);
      for (int b = 0; b < LINE_BYTES; b++) begin
        rnd = $random(seed);
        mem_model[l*LINE_BYTES + b] = rnd[7:0];
        wr_data[8*b +: 8] <= rnd[7:0];
      end
    end
    @(posedge clk);
    wr_en <= 1'b0;

    for (int i = 0; i < N_ROWS; i++) begin
      run_row(rows[i]);
    end
    $display("Simulation PASSED");
    $finish;
  end

endmodule

// File: accel_dma.f
verilog/accel_dma_pkg.sv
verilog/dual_bank_mem.sv
verilog/rd_desc_ctrl.sv
verilog/line_credit_cnt.sv
verilog/line_aligner.sv
verilog/line_fifo.sv
verilog/accel_width_conv.sv
verilog/accel_rd_dma_top.sv
dv/tb_clk_gen.sv
dv/accel_rd_dma_tb.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing -Wno-fatal
TOP      := accel_rd_dma_tb
FILELIST := accel_dma.f
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
SRCS     := $(shell cat $(FILELIST))

.PHONY: run clean

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^Simulation PASSED$$" $(LOG)

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
